// ==== verilog/lsu_config.svh ====
// build-time sizes of the vector load/store unit
// LSU_VREG_W must be a multiple of LSU_VMEM_W, and LSU_VMEM_W is fixed at 32 bits

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// vector register width in bits
`define LSU_VREG_W 128

// memory data port width in bits
`define LSU_VMEM_W 32

`define LSU_ADDR_W 32

// vl counts elements, 0 up to 16
`define LSU_VL_W 5

// memory beats per vector register
`define LSU_BEATS (`LSU_VREG_W / `LSU_VMEM_W)

`endif

// ==== verilog/lsu_pkg.sv ====
// shared types of the vector load/store unit
// only unit-stride accesses of one vector register are described here

`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

    typedef enum logic {
        LSU_LOAD,
        LSU_STORE
    } lsu_op_e;

    typedef enum logic [1:0] {
        EEW_8,
        EEW_16,
        EEW_32
    } lsu_eew_e;

    // operation descriptor as handed in by the issue logic
    typedef struct packed {
        lsu_op_e                 kind;
        lsu_eew_e                eew;
        logic [`LSU_VL_W-1:0]    vl;
        logic [`LSU_ADDR_W-1:0]  base;
        logic [4:0]              vreg;
    } lsu_op_t;

    typedef struct packed {
        logic                    req;
        logic [`LSU_ADDR_W-1:0]  addr;
        logic                    we;
        logic [`LSU_VMEM_W/8-1:0] be;
        logic [`LSU_VMEM_W-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    gnt;
        logic                    rvalid;
        logic [`LSU_VMEM_W-1:0]  rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                    en;
        logic [4:0]              addr;
        logic [`LSU_VREG_W/8-1:0] mask;
        logic [`LSU_VREG_W-1:0]  data;
    } vreg_wr_t;

    // byte b is live when it belongs to one of the first vl elements,
    // vl saturates at the element count of one register
    function automatic logic [`LSU_VREG_W/8-1:0] vl_byte_mask(lsu_eew_e eew,
                                                             logic [`LSU_VL_W-1:0] vl);
        logic [`LSU_VREG_W/8-1:0] mask;
        int unsigned esize;
        int unsigned nelem;
        int unsigned nbytes;
        case (eew)
            EEW_8:   esize = 1;
            EEW_16:  esize = 2;
            default: esize = 4;
        endcase
        nelem  = (`LSU_VREG_W / 8) / esize;
        nbytes = ((int'(vl) > nelem) ? nelem : int'(vl)) * esize;
        for (int b = 0; b < `LSU_VREG_W / 8; b++) begin
            mask[b] = (b < nbytes);
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/lsu_op_ctrl.sv ====
// one operation at a time, the descriptor on op_o holds until the last done pulse
// a base address that is not word-aligned is refused and never started

`timescale 1ns/10ps
`default_nettype none

module lsu_op_ctrl (
    input  wire logic              clk_i,
    input  wire logic              async_rst_n,
    input  wire logic              op_valid_i,
    input  wire lsu_pkg::lsu_op_t  op_i,
    input  wire logic              req_done_i,
    input  wire logic              load_done_i,
    output logic                   op_ready_o,
    output logic                   misaligned_o,
    output logic                   start_o,
    output lsu_pkg::lsu_op_t       op_o,
    output logic                   pending_load_o,
    output logic                   pending_store_o
);

    import lsu_pkg::*;

    typedef enum logic {
        IDLE,
        BUSY
    } ctrl_state_e;

    ctrl_state_e state_q, state_d;
    logic        accept;
    logic        aligned;
    logic        req_pend_q, req_pend_d;
    logic        load_pend_q, load_pend_d;
    lsu_op_t     op_q;

    assign op_ready_o   = (state_q == IDLE);
    assign accept       = op_valid_i & op_ready_o;
    assign aligned      = (op_i.base[1:0] == 2'b00);
    assign misaligned_o = accept & ~aligned;
    assign start_o      = accept & aligned;

    // pass through while idle so the datapath sees the descriptor with start
    assign op_o = op_ready_o ? op_i : op_q;

    ////////////////////////////////////////////////////////////
    // completion tracking

    always_comb begin
        req_pend_d  = req_pend_q & ~req_done_i;
        load_pend_d = load_pend_q & ~load_done_i;
        if (start_o) begin
            req_pend_d  = 1'b1;
            load_pend_d = (op_i.kind == LSU_LOAD);
        end
        state_d = (req_pend_d | load_pend_d) ? BUSY : IDLE;
    end

    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            state_q     <= IDLE;
            req_pend_q  <= 1'b0;
            load_pend_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_pend_q  <= req_pend_d;
            load_pend_q <= load_pend_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_o) begin
            op_q <= op_i;
        end
    end

    assign pending_load_o  = (state_q == BUSY) & (op_q.kind == LSU_LOAD);
    assign pending_store_o = (state_q == BUSY) & (op_q.kind == LSU_STORE);

    // no new start while a done pulse of the previous operation is still owed
    a_start_from_idle: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        start_o |-> !req_pend_q && !load_pend_q)
        else $error("start_o fired while the unit was busy");

endmodule

`default_nettype wire

// ==== verilog/lsu_request.sv ====
// issues the memory beats of one unit-stride access, base + 4k for beat k
// store data comes from a combinational register-file read port

`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module lsu_request (
    input  wire logic                    clk_i,
    input  wire logic                    async_rst_n,
    input  wire logic                    start_i,
    input  wire lsu_pkg::lsu_op_t        op_i,
    input  wire logic [`LSU_VREG_W-1:0]  vreg_rd_data_i,
    input  wire lsu_pkg::mem_rsp_t       mem_rsp_i,
    output logic [4:0]                   vreg_rd_addr_o,
    output lsu_pkg::mem_req_t            mem_req_o,
    output logic                         req_done_o
);

    import lsu_pkg::*;

    localparam int unsigned BEAT_W     = $clog2(`LSU_BEATS);
    localparam int unsigned BEAT_BYTES = `LSU_VMEM_W / 8;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        REQUEST
    } req_state_e;

    req_state_e                state_q, state_d;
    logic [BEAT_W-1:0]         beat_q, beat_d;
    logic [`LSU_VREG_W-1:0]    store_q;
    logic [`LSU_VREG_W/8-1:0]  vl_mask;
    logic                      granted;
    logic                      last_beat;

    assign vl_mask   = vl_byte_mask(op_i.eew, op_i.vl);
    assign granted   = (state_q == REQUEST) & mem_rsp_i.gnt;
    assign last_beat = (beat_q == BEAT_W'(`LSU_BEATS - 1));

    // source register of a store, read in the FETCH cycle
    assign vreg_rd_addr_o = op_i.vreg;

    ////////////////////////////////////////////////////////////
    // sequencing

    always_comb begin
        state_d = state_q;
        beat_d  = beat_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    beat_d  = '0;
                    state_d = (op_i.kind == LSU_STORE) ? FETCH : REQUEST;
                end
            end
            FETCH: begin
                state_d = REQUEST;
            end
            REQUEST: begin
                if (mem_rsp_i.gnt) begin
                    beat_d = beat_q + 1'b1;
                    if (last_beat) begin
                        state_d = IDLE;
                    end
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            state_q <= IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            beat_q  <= beat_d;
        end
    end

    // lowest word always holds the data of the current beat
    always_ff @(posedge clk_i) begin
        if (state_q == FETCH) begin
            store_q <= vreg_rd_data_i;
        end else if (granted) begin
            store_q <= {{`LSU_VMEM_W{1'b0}}, store_q[`LSU_VREG_W-1:`LSU_VMEM_W]};
        end
    end

    ////////////////////////////////////////////////////////////
    // memory request

    always_comb begin
        mem_req_o.req   = (state_q == REQUEST);
        mem_req_o.addr  = op_i.base + (`LSU_ADDR_W'(beat_q) << $clog2(BEAT_BYTES));
        mem_req_o.we    = (op_i.kind == LSU_STORE);
        mem_req_o.be    = '1;
        if (op_i.kind == LSU_STORE) begin
            mem_req_o.be = vl_mask[beat_q*BEAT_BYTES +: BEAT_BYTES];
        end
        mem_req_o.wdata = store_q[`LSU_VMEM_W-1:0];
    end

    assign req_done_o = granted & last_beat;

    // a pending request may not change until the memory grants it
    a_req_stable: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        mem_req_o.req && !mem_rsp_i.gnt |=> $stable(mem_req_o))
        else $error("memory request changed before its grant");

endmodule

`default_nettype wire

// ==== verilog/lsu_load_assembler.sv ====
// gathers the in-order read beats of one load and writes the register once
// the descriptor on op_i must stay stable until load_done_o

`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module lsu_load_assembler (
    input  wire logic              clk_i,
    input  wire logic              async_rst_n,
    input  wire logic              start_i,
    input  wire lsu_pkg::lsu_op_t  op_i,
    input  wire lsu_pkg::mem_rsp_t mem_rsp_i,
    output lsu_pkg::vreg_wr_t      vreg_wr_o,
    output logic                   load_done_o
);

    import lsu_pkg::*;

    localparam int unsigned BEAT_W = $clog2(`LSU_BEATS);

    logic                    armed_q;
    logic [BEAT_W-1:0]       beat_q;
    logic                    wr_en_q;
    logic [`LSU_VREG_W-1:0]  shift_q;
    logic                    take;
    logic                    last_beat;

    assign take      = armed_q & mem_rsp_i.rvalid;
    assign last_beat = (beat_q == BEAT_W'(`LSU_BEATS - 1));

    ////////////////////////////////////////////////////////////
    // beat tracking

    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            armed_q <= 1'b0;
            beat_q  <= '0;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            if (start_i && op_i.kind == LSU_LOAD) begin
                armed_q <= 1'b1;
                beat_q  <= '0;
            end else if (take) begin
                beat_q <= beat_q + 1'b1;
                if (last_beat) begin
                    armed_q <= 1'b0;
                    wr_en_q <= 1'b1;
                end
            end
        end
    end

    // new beats enter at the top, beat 0 settles in the lowest word
    always_ff @(posedge clk_i) begin
        if (take) begin
            shift_q <= {mem_rsp_i.rdata, shift_q[`LSU_VREG_W-1:`LSU_VMEM_W]};
        end
    end

    ////////////////////////////////////////////////////////////
    // write-back

    always_comb begin
        vreg_wr_o.en   = wr_en_q;
        vreg_wr_o.addr = op_i.vreg;
        vreg_wr_o.mask = vl_byte_mask(op_i.eew, op_i.vl);
        vreg_wr_o.data = shift_q;
    end

    assign load_done_o = wr_en_q;

    // read data only ever answers a load that is still collecting beats
    a_rvalid_armed: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        mem_rsp_i.rvalid |-> armed_q)
        else $error("read data returned with no load in flight");

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
// vector load/store unit, unit-stride only, one operation in flight
// memory uses a req/gnt/rvalid handshake with in-order read data

`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top (
    input  wire logic                    clk_i,
    input  wire logic                    async_rst_n,
    input  wire logic                    op_valid_i,
    input  wire lsu_pkg::lsu_op_t        op_i,
    input  wire lsu_pkg::mem_rsp_t       mem_rsp_i,
    input  wire logic [`LSU_VREG_W-1:0]  vreg_rd_data_i,
    output logic                         op_ready_o,
    output logic                         misaligned_o,
    output logic                         pending_load_o,
    output logic                         pending_store_o,
    output lsu_pkg::mem_req_t            mem_req_o,
    output logic [4:0]                   vreg_rd_addr_o,
    output lsu_pkg::vreg_wr_t            vreg_wr_o
);

    import lsu_pkg::*;

    logic    start;
    lsu_op_t op;
    logic    req_done;
    logic    load_done;

    lsu_op_ctrl u_lsu_op_ctrl (
        .clk_i           (clk_i),
        .async_rst_n     (async_rst_n),
        .op_valid_i      (op_valid_i),
        .op_i            (op_i),
        .req_done_i      (req_done),
        .load_done_i     (load_done),
        .op_ready_o      (op_ready_o),
        .misaligned_o    (misaligned_o),
        .start_o         (start),
        .op_o            (op),
        .pending_load_o  (pending_load_o),
        .pending_store_o (pending_store_o)
    );

    // request side and load side run in parallel
    lsu_request u_lsu_request (
        .clk_i          (clk_i),
        .async_rst_n    (async_rst_n),
        .start_i        (start),
        .op_i           (op),
        .vreg_rd_data_i (vreg_rd_data_i),
        .mem_rsp_i      (mem_rsp_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .mem_req_o      (mem_req_o),
        .req_done_o     (req_done)
    );

    lsu_load_assembler u_lsu_load_assembler (
        .clk_i       (clk_i),
        .async_rst_n (async_rst_n),
        .start_i     (start),
        .op_i        (op),
        .mem_rsp_i   (mem_rsp_i),
        .vreg_wr_o   (vreg_wr_o),
        .load_done_o (load_done)
    );

endmodule

`default_nettype wire

// ==== tests/lsu_tb_env.sv ====
// memory and vector register-file models for the load/store unit testbench
// 64-word memory indexed by addr[7:2], grants after 0 to 2 cycles, read data 1 to 3 later

`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb_env (
    input  wire logic                    clk_i,
    input  wire logic                    async_rst_n,
    input  wire lsu_pkg::mem_req_t       mem_req_i,
    output lsu_pkg::mem_rsp_t            mem_rsp_o,
    input  wire logic [4:0]              vreg_rd_addr_i,
    output logic [`LSU_VREG_W-1:0]       vreg_rd_data_o,
    input  wire lsu_pkg::vreg_wr_t       vreg_wr_i
);

    import lsu_pkg::*;

    logic [31:0]             mem [64];
    logic [`LSU_VREG_W-1:0]  regs [32];
    logic [31:0]             rd_data_q [$];
    int                      rd_due_q [$];
    int                      seed = 14;
    int                      cyc = 0;
    int                      wait_left = 0;
    logic                    waiting = 1'b0;

    // combinational read port of the register file
    assign vreg_rd_data_o = regs[vreg_rd_addr_i];

    initial begin
        mem_rsp_o = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'(i + 1) * 32'h9E3779B9;
        end
        for (int r = 0; r < 32; r++) begin
            for (int k = 0; k < 4; k++) begin
                regs[r][k*32 +: 32] = 32'(r * 4 + k + 101) * 32'h85EBCA6B;
            end
        end
        forever begin
            @(negedge clk_i);
            cyc++;
            mem_rsp_o.gnt    = 1'b0;
            mem_rsp_o.rvalid = 1'b0;
            if (!async_rst_n) begin
                rd_data_q.delete();
                rd_due_q.delete();
                waiting = 1'b0;
            end else begin
                // register write-back, valid for the whole cycle
                if (vreg_wr_i.en) begin
                    for (int b = 0; b < `LSU_VREG_W / 8; b++) begin
                        if (vreg_wr_i.mask[b]) begin
                            regs[vreg_wr_i.addr][b*8 +: 8] = vreg_wr_i.data[b*8 +: 8];
                        end
                    end
                end
                // in-order read return
                if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
                    mem_rsp_o.rvalid = 1'b1;
                    mem_rsp_o.rdata  = rd_data_q.pop_front();
                    void'(rd_due_q.pop_front());
                end
                if (mem_req_i.req) begin
                    if (!waiting) begin
                        waiting   = 1'b1;
                        wait_left = int'($unsigned($random(seed)) % 3);
                    end
                    if (wait_left == 0) begin
                        mem_rsp_o.gnt = 1'b1;
                        waiting       = 1'b0;
                        if (mem_req_i.we) begin
                            for (int j = 0; j < 4; j++) begin
                                if (mem_req_i.be[j]) begin
                                    mem[mem_req_i.addr[7:2]][j*8 +: 8] = mem_req_i.wdata[j*8 +: 8];
                                end
                            end
                        end else begin
                            rd_data_q.push_back(mem[mem_req_i.addr[7:2]]);
                            rd_due_q.push_back(cyc + 1 + int'($unsigned($random(seed)) % 3));
                        end
                    end else begin
                        wait_left--;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/lsu_tb.sv ====
// testbench of the vector load/store unit, checks are concurrent assertions
// bases stay below 256 so the 64-word memory model wraps on addr[7:2]

`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;

    import lsu_pkg::*;

    localparam int NUM_RANDOM = 40;
    localparam int NUM_OPS    = NUM_RANDOM + 15;

    logic                    clk_i;
    logic                    async_rst_n;
    logic                    op_valid_i;
    lsu_op_t                 op_i;
    mem_rsp_t                mem_rsp;
    logic [`LSU_VREG_W-1:0]  vreg_rd_data;
    logic                    op_ready_o;
    logic                    misaligned_o;
    logic                    pending_load_o;
    logic                    pending_store_o;
    mem_req_t                mem_req_o;
    logic [4:0]              vreg_rd_addr;
    vreg_wr_t                vreg_wr_o;

    int                      seed = 14;
    lsu_op_e                 exp_kind = LSU_LOAD;
    logic [31:0]             exp_base = '0;
    logic [4:0]              exp_vreg = '0;
    logic [15:0]             exp_mask = '0;
    logic [127:0]            exp_data = '0;
    logic [31:0]             exp_mem [64];
    logic [127:0]            exp_regs [32];
    int                      beat_cnt = 0;
    int                      wr_cnt = 0;
    logic [1:0]              beat_idx;
    logic [31:0]             exp_addr;
    logic [3:0]              exp_be;
    logic [31:0]             exp_wdata;
    logic                    images_ok = 1'b1;

    lsu_top u_lsu_top (
        .clk_i           (clk_i),
        .async_rst_n     (async_rst_n),
        .op_valid_i      (op_valid_i),
        .op_i            (op_i),
        .mem_rsp_i       (mem_rsp),
        .vreg_rd_data_i  (vreg_rd_data),
        .op_ready_o      (op_ready_o),
        .misaligned_o    (misaligned_o),
        .pending_load_o  (pending_load_o),
        .pending_store_o (pending_store_o),
        .mem_req_o       (mem_req_o),
        .vreg_rd_addr_o  (vreg_rd_addr),
        .vreg_wr_o       (vreg_wr_o)
    );

    lsu_tb_env u_env (
        .clk_i          (clk_i),
        .async_rst_n    (async_rst_n),
        .mem_req_i      (mem_req_o),
        .mem_rsp_o      (mem_rsp),
        .vreg_rd_addr_i (vreg_rd_addr),
        .vreg_rd_data_o (vreg_rd_data),
        .vreg_wr_i      (vreg_wr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // byte mask of the first vl elements, elements past the register are dropped
    function automatic logic [15:0] expected_mask(lsu_eew_e eew, logic [4:0] vl);
        logic [15:0] m;
        int          esize;
        esize = (eew == EEW_8) ? 1 : ((eew == EEW_16) ? 2 : 4);
        m = '0;
        for (int e = 0; e < 16; e++) begin
            if (e < int'(vl) && (e + 1) * esize <= 16) begin
                for (int b = 0; b < esize; b++) begin
                    m[e*esize+b] = 1'b1;
                end
            end
        end
        return m;
    endfunction

    task automatic report_mismatch(string name, logic [127:0] got, logic [127:0] exp);
        $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_error(string what);
        $display("ERROR %s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////
    // expected beat values and bookkeeping

    assign beat_idx  = beat_cnt[1:0];
    assign exp_addr  = exp_base + 32'({beat_idx, 2'b00});
    assign exp_be    = (exp_kind == LSU_STORE) ? exp_mask[{beat_idx, 2'b00} +: 4] : 4'hf;
    assign exp_wdata = exp_regs[exp_vreg][{beat_idx, 5'b00000} +: 32];

    always @(posedge clk_i) begin
        if (op_valid_i && op_ready_o) begin
            beat_cnt <= 0;
            wr_cnt   <= 0;
        end else begin
            if (mem_req_o.req && mem_rsp.gnt) begin
                beat_cnt <= beat_cnt + 1;
            end
            if (vreg_wr_o.en) begin
                wr_cnt <= wr_cnt + 1;
            end
        end
    end

    always @(negedge clk_i) begin
        images_ok = 1'b1;
        for (int i = 0; i < 64; i++) begin
            if (u_env.mem[i] !== exp_mem[i]) images_ok = 1'b0;
        end
        for (int r = 0; r < 32; r++) begin
            if (u_env.regs[r] !== exp_regs[r]) images_ok = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks

    a_rst_ready: assert property (@(posedge clk_i) !async_rst_n |-> op_ready_o)
        else report_mismatch("op_ready_o", 128'($sampled(op_ready_o)), 128'(1'b1));
    a_rst_req: assert property (@(posedge clk_i) !async_rst_n |-> !mem_req_o.req)
        else report_mismatch("mem_req_o.req", 128'($sampled(mem_req_o.req)), 128'(1'b0));
    a_rst_wr: assert property (@(posedge clk_i) !async_rst_n |-> !vreg_wr_o.en)
        else report_mismatch("vreg_wr_o.en", 128'($sampled(vreg_wr_o.en)), 128'(1'b0));

    a_stable: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        mem_req_o.req && !mem_rsp.gnt |=> $stable(mem_req_o))
        else report_error("memory request changed while waiting for its grant");
    a_addr: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        mem_req_o.req && mem_rsp.gnt |-> mem_req_o.addr == exp_addr)
        else report_mismatch("mem_req_o.addr", 128'($sampled(mem_req_o.addr)),
                             128'($sampled(exp_addr)));
    a_we: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        mem_req_o.req && mem_rsp.gnt |-> mem_req_o.we == (exp_kind == LSU_STORE))
        else report_mismatch("mem_req_o.we", 128'($sampled(mem_req_o.we)),
                             128'($sampled(exp_kind == LSU_STORE)));
    a_be: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        mem_req_o.req && mem_rsp.gnt |-> mem_req_o.be == exp_be)
        else report_mismatch("mem_req_o.be", 128'($sampled(mem_req_o.be)),
                             128'($sampled(exp_be)));
    a_wdata: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        mem_req_o.req && mem_rsp.gnt && mem_req_o.we |-> mem_req_o.wdata == exp_wdata)
        else report_mismatch("mem_req_o.wdata", 128'($sampled(mem_req_o.wdata)),
                             128'($sampled(exp_wdata)));

    // source register of a store is addressed in the cycle after acceptance
    a_rd_addr: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        op_valid_i && op_ready_o && op_i.base[1:0] == 2'b00 && op_i.kind == LSU_STORE
        |=> vreg_rd_addr == exp_vreg)
        else report_mismatch("vreg_rd_addr_o", 128'($sampled(vreg_rd_addr)),
                             128'($sampled(exp_vreg)));

    a_wr_addr: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        vreg_wr_o.en |-> vreg_wr_o.addr == exp_vreg)
        else report_mismatch("vreg_wr_o.addr", 128'($sampled(vreg_wr_o.addr)),
                             128'($sampled(exp_vreg)));
    a_wr_mask: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        vreg_wr_o.en |-> vreg_wr_o.mask == exp_mask)
        else report_mismatch("vreg_wr_o.mask", 128'($sampled(vreg_wr_o.mask)),
                             128'($sampled(exp_mask)));
    a_wr_data: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        vreg_wr_o.en |-> vreg_wr_o.data == exp_data)
        else report_mismatch("vreg_wr_o.data", $sampled(vreg_wr_o.data), $sampled(exp_data));

    // end of an operation, counted at the cycle op_ready_o comes back
    a_beats: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        $rose(op_ready_o) |-> beat_cnt == 4)
        else report_mismatch("beat count", 128'($sampled(beat_cnt)), 128'(4));
    a_writes: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        $rose(op_ready_o) |-> wr_cnt == ((exp_kind == LSU_LOAD) ? 1 : 0))
        else report_mismatch("register write count", 128'($sampled(wr_cnt)),
                             128'($sampled(exp_kind == LSU_LOAD)));
    a_images: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        $rose(op_ready_o) |-> images_ok)
        else report_error("memory or register file differs from the expected image");

    a_misaligned: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        op_valid_i && op_ready_o && op_i.base[1:0] != 2'b00 |-> misaligned_o)
        else report_mismatch("misaligned_o", 128'($sampled(misaligned_o)), 128'(1'b1));
    a_misaligned_idle: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        misaligned_o |=> op_ready_o && !mem_req_o.req)
        else report_error("a misaligned operation was started");
    a_pend_load: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        op_valid_i && op_ready_o && op_i.base[1:0] == 2'b00 && op_i.kind == LSU_LOAD
        |=> pending_load_o && !pending_store_o)
        else report_error("pending flags do not show an accepted load");
    a_pend_store: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        op_valid_i && op_ready_o && op_i.base[1:0] == 2'b00 && op_i.kind == LSU_STORE
        |=> pending_store_o && !pending_load_o)
        else report_error("pending flags do not show an accepted store");
    a_pend_idle: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        op_ready_o |-> !pending_load_o && !pending_store_o)
        else report_error("a pending flag is high while the unit is ready");

    ////////////////////////////////////////////////////////////
    // stimulus

    task automatic run_op(lsu_op_e kind, lsu_eew_e eew, logic [4:0] vl,
                          logic [31:0] base, logic [4:0] vreg);
        int widx;
        @(negedge clk_i);
        while (!op_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        op_valid_i = 1'b1;
        op_i.kind  = kind;
        op_i.eew   = eew;
        op_i.vl    = vl;
        op_i.base  = base;
        op_i.vreg  = vreg;
        if (base[1:0] == 2'b00) begin
            exp_kind = kind;
            exp_base = base;
            exp_vreg = vreg;
            exp_mask = expected_mask(eew, vl);
            for (int k = 0; k < 4; k++) begin
                widx = (int'(base[7:2]) + k) % 64;
                exp_data[k*32 +: 32] = exp_mem[widx];
                for (int j = 0; j < 4; j++) begin
                    if (kind == LSU_STORE && exp_mask[k*4+j]) begin
                        exp_mem[widx][j*8 +: 8] = exp_regs[vreg][k*32+j*8 +: 8];
                    end
                end
            end
            if (kind == LSU_LOAD) begin
                for (int b = 0; b < 16; b++) begin
                    if (exp_mask[b]) exp_regs[vreg][b*8 +: 8] = exp_data[b*8 +: 8];
                end
            end
        end
        @(negedge clk_i);
        op_valid_i = 1'b0;
    endtask

    initial begin
        lsu_op_e     kind;
        lsu_eew_e    eew;
        logic [4:0]  vl;
        logic [31:0] base;
        int unsigned pick;
        async_rst_n = 1'b0;
        op_valid_i  = 1'b0;
        op_i        = '0;
        #1;
        for (int i = 0; i < 64; i++) exp_mem[i] = u_env.mem[i];
        for (int r = 0; r < 32; r++) exp_regs[r] = u_env.regs[r];
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_n = 1'b1;

        // vl of zero and of its maximum for every element width
        for (int e = 0; e < 3; e++) begin
            eew = (e == 0) ? EEW_8 : ((e == 1) ? EEW_16 : EEW_32);
            run_op(LSU_STORE, eew, 5'd0, 32'(e * 16), 5'(e + 1));
            run_op(LSU_LOAD, eew, 5'd0, 32'(e * 16 + 64), 5'(e + 4));
            run_op(LSU_STORE, eew, 5'd16, 32'(e * 16 + 128), 5'(e + 7));
            run_op(LSU_LOAD, eew, 5'd16, 32'(e * 16 + 128), 5'(e + 10));
        end
        for (int m = 1; m < 4; m++) begin
            run_op((m == 2) ? LSU_STORE : LSU_LOAD, EEW_8, 5'd7, 32'(20 + m), 5'd3);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            kind = ($random(seed) & 1) ? LSU_STORE : LSU_LOAD;
            pick = $unsigned($random(seed)) % 3;
            eew  = (pick == 0) ? EEW_8 : ((pick == 1) ? EEW_16 : EEW_32);
            vl   = 5'($unsigned($random(seed)) % 17);
            base = 32'($unsigned($random(seed)) % 64) << 2;
            if ($unsigned($random(seed)) % 8 == 0) begin
                base[1:0] = 2'($unsigned($random(seed)) % 3 + 1);
            end
            run_op(kind, eew, vl, base, 5'($random(seed)));
        end

        @(negedge clk_i);
        while (!op_ready_o) @(negedge clk_i);
        repeat (2) @(negedge clk_i);
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        repeat (NUM_OPS * 60 + 8) @(posedge clk_i);
        $display("watchdog expired before the operation sequence finished");
        $display("*** FAILED ***");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_op_ctrl.sv
verilog/lsu_request.sv
verilog/lsu_load_assembler.sv
verilog/lsu_top.sv
tests/lsu_tb_env.sv
tests/lsu_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f list.f --top-module lsu_tb \
		--Mdir obj_dir -o lsu_tb_sim
	./obj_dir/lsu_tb_sim

clean:
	rm -rf obj_dir
